// ==== files.f ====
+incdir+hdl
hdl/BoardCtrlPkg.sv
hdl/StrobeIf.sv
hdl/ButtonIf.sv
hdl/StrobeGen.sv
hdl/ButtonControl.sv
hdl/PwrSequence.sv
hdl/BoardCtrl.sv
verification/ClockGen.sv
verification/BoardCtrl_properties.sv
verification/BoardCtrlTb.sv

// ==== hdl/BoardCtrl.sv ====
//--------------------------------------------------------------------------
// Board power control top level
// Strobe generator, button control and power sequencer as a three-stage
// pipeline on the 32.768 kHz standby clock, with plain board ports
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module BoardCtrl import BoardCtrlPkg::*; (
    input  logic CLK32768,          // 32.768 kHz standby clock
    input  logic reset,             // Sync, active high
    input  logic powerButtonN,      // Front panel power button
    input  logic resetButtonN,      // Front panel reset button
    input  logic psPowerOk,         // PSU power-OK
    input  logic mainPowerGood,     // Main/PCH rails good
    input  logic cpuPowerGood,      // CPU core good
    input  logic memAbPowerGood,    // Memory AB good
    input  logic memCdPowerGood,    // Memory CD good
    output logic psEnable,          // PSU on
    output logic mainEnable,        // Main/PCH rails on
    output logic cpuEnable,         // CPU core on
    output logic memEnable,         // Memory rails on
    output logic sysPowerOk,        // System power-OK
    output logic platformResetN,    // Platform reset
    output logic faultLedN,         // Fault LED
    output logic sioPowerButtonN    // Debounced power button to SIO
);

    StrobeIf        strobeBus ();
    ButtonIf        buttonBus ();
    railEnables_t   railEnables;

    StrobeGen uStrobeGen (
        .CLK32768       (CLK32768),
        .reset          (reset),
        .strobes        (strobeBus.source)
    );

    ButtonControl uButtonControl (
        .CLK32768       (CLK32768),
        .reset          (reset),
        .strobes        (strobeBus.sink),
        .powerButtonN   (powerButtonN),
        .resetButtonN   (resetButtonN),
        .buttons        (buttonBus.source),
        .sioPowerButtonN(sioPowerButtonN)
    );

    PwrSequence uPwrSequence (
        .CLK32768       (CLK32768),
        .reset          (reset),
        .strobes        (strobeBus.sink),
        .buttons        (buttonBus.sink),
        .psPowerOk      (psPowerOk),
        .mainPowerGood  (mainPowerGood),
        .cpuPowerGood   (cpuPowerGood),
        .memAbPowerGood (memAbPowerGood),
        .memCdPowerGood (memCdPowerGood),
        .railEnables    (railEnables),
        .sysPowerOk     (sysPowerOk),
        .platformResetN (platformResetN),
        .faultLedN      (faultLedN)
    );

    // Rail enables out to the regulator pins
    assign psEnable   = railEnables.supply;
    assign mainEnable = railEnables.main;
    assign cpuEnable  = railEnables.cpu;
    assign memEnable  = railEnables.mem;

endmodule

`default_nettype wire

// ==== hdl/BoardCtrlPkg.sv ====
//--------------------------------------------------------------------------
// Board power control types
// Sequencer state encoding and the packed rail-enable vector
//--------------------------------------------------------------------------
`default_nettype none

package BoardCtrlPkg;

    // Order matters, enables decode from the state value
    typedef enum logic [2:0] {
        SeqOff       = 3'd0,    // All rails off
        SeqSupplyOn  = 3'd1,    // PSU on, wait PS power-OK
        SeqMainOn    = 3'd2,    // Main/PCH rails, wait main good
        SeqCpuOn     = 3'd3,    // CPU core, wait core good
        SeqMemOn     = 3'd4,    // Memory rails, wait AB and CD good
        SeqSysOkWait = 3'd5,    // Delay before system power-OK
        SeqRunning   = 3'd6,    // Fully powered
        SeqFault     = 3'd7     // Shut down, fault LED lit
    } seqState_t;

    // Supply in the MSB, 4'hF means every rail on
    typedef struct packed {
        logic supply;           // PSU enable
        logic main;             // Main/PCH enable
        logic cpu;              // CPU core enable
        logic mem;              // Memory VPP/VDDQ enable
    } railEnables_t;

endpackage

`default_nettype wire

// ==== hdl/ButtonControl.sv ====
//--------------------------------------------------------------------------
// Button control
// Debounces the power and reset buttons on 16 ms samples, turns a power
// press into a toggle event and a reset held 4 s into a reset request.
// Also drives the debounced power button to the SIO
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "boardCtrl_consts.svh"

module ButtonControl (
    input  logic    CLK32768,           // 32.768 kHz standby clock
    input  logic    reset,              // Sync, active high
    StrobeIf.sink   strobes,            // Uses 16 ms and 1 s
    input  logic    powerButtonN,       // Raw, low when pressed
    input  logic    resetButtonN,       // Raw, low when pressed
    ButtonIf.source buttons,            // Levels and events out
    output logic    sioPowerButtonN     // Debounced power button to SIO
);

    localparam int SampleWidth = $clog2(`DEBOUNCE_SAMPLES);
    localparam int HoldWidth   = $clog2(`RESET_HOLD_SECONDS + 1);

    logic [1:0]             rawSync1;           // Bit 0 power, bit 1 reset
    logic [1:0]             rawSync2;           // Pressed is high
    logic [1:0]             level;              // Debounced levels
    logic [SampleWidth-1:0] sampleCount [2];    // Differing samples seen
    logic                   powerLevelDly;
    logic [HoldWidth-1:0]   holdSeconds;        // Saturates at hold time

    // Buttons are asynchronous to the slow clock
    always_ff @(posedge CLK32768) begin
        rawSync1 <= {~resetButtonN, ~powerButtonN};
        rawSync2 <= rawSync1;
    end

    //----------------------------------------------------------------------
    // Debounce, a new level needs consecutive differing samples
    //----------------------------------------------------------------------
    always_ff @(posedge CLK32768) begin
        if (reset) begin
            level          <= '0;
            sampleCount[0] <= '0;
            sampleCount[1] <= '0;
        end else if (strobes.strobe16ms) begin
            for (int i = 0; i < 2; i++) begin
                if (rawSync2[i] == level[i]) begin
                    sampleCount[i] <= '0;                   // Bounce, restart
                end else if (sampleCount[i] == SampleWidth'(`DEBOUNCE_SAMPLES - 1)) begin
                    level[i]       <= rawSync2[i];          // Accept new level
                    sampleCount[i] <= '0;
                end else begin
                    sampleCount[i] <= sampleCount[i] + 1'b1;
                end
            end
        end
    end

    //----------------------------------------------------------------------
    // Power press edge and reset hold timer
    //----------------------------------------------------------------------
    always_ff @(posedge CLK32768) begin
        if (reset) begin
            powerLevelDly       <= 1'b0;
            buttons.powerToggle <= 1'b0;
            holdSeconds         <= '0;
        end else begin
            powerLevelDly       <= level[0];
            buttons.powerToggle <= level[0] & ~powerLevelDly;   // Press edge only
            if (!level[1]) begin
                holdSeconds <= '0;                              // Released, rearm
            end else if (strobes.strobe1s &&
                         holdSeconds != HoldWidth'(`RESET_HOLD_SECONDS)) begin
                holdSeconds <= holdSeconds + 1'b1;
            end
        end
    end

    assign buttons.powerLevel   = level[0];
    assign buttons.resetLevel   = level[1];
    // Fires on the strobe that completes the hold, once per hold
    assign buttons.resetRequest = strobes.strobe1s & level[1] &
                                  (holdSeconds == HoldWidth'(`RESET_HOLD_SECONDS - 1));
    assign sioPowerButtonN      = ~buttons.powerLevel;

endmodule

`default_nettype wire

// ==== hdl/ButtonIf.sv ====
//--------------------------------------------------------------------------
// Button bundle
// Debounced button levels and single-cycle button events
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface ButtonIf;

    logic powerLevel;           // Debounced, high while pressed
    logic resetLevel;           // Debounced, high while pressed
    logic powerToggle;          // One cycle per power press
    logic resetRequest;         // One cycle per long reset hold

    modport source (
        output powerLevel, resetLevel, powerToggle, resetRequest
    );

    modport sink (
        input powerLevel, resetLevel, powerToggle, resetRequest
    );

endinterface

`default_nettype wire

// ==== hdl/PwrSequence.sv ====
//--------------------------------------------------------------------------
// Power sequencer
// Turns on supply, main/PCH, CPU core and memory rails in order, each
// after the previous power-good, then asserts system power-OK and
// releases platform reset. Power-good loss or a 1 s rail timeout shuts
// every rail down and lights the fault LED until the next power press
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "boardCtrl_consts.svh"

module PwrSequence import BoardCtrlPkg::*; (
    input  logic            CLK32768,           // 32.768 kHz standby clock
    input  logic            reset,              // Sync, active high
    StrobeIf.sink           strobes,            // Uses 1 ms and 125 ms
    ButtonIf.sink           buttons,            // Toggle, reset request
    input  logic            psPowerOk,          // PSU power-OK
    input  logic            mainPowerGood,      // Main/PCH rails good
    input  logic            cpuPowerGood,       // CPU core good
    input  logic            memAbPowerGood,     // Memory AB good
    input  logic            memCdPowerGood,     // Memory CD good
    output railEnables_t    railEnables,        // Rail enables
    output logic            sysPowerOk,         // System power-OK
    output logic            platformResetN,     // Platform reset, low active
    output logic            faultLedN           // Fault LED, low lit
);

    localparam int TimerWidth = $clog2(`RAIL_TIMEOUT_STROBES + 1);
    localparam int PulseWidth = $clog2(`RESET_PULSE_MS + 1);

    seqState_t              state;
    seqState_t              nextState;
    logic [TimerWidth-1:0]  timer;          // 125 ms strobes in this state
    logic [PulseWidth-1:0]  pulseCount;     // Remaining reset pulse
    logic                   memPowerGood;
    logic                   allGood;
    logic                   timedOut;
    logic                   sysOkDone;
    logic                   resetReady;     // One cycle behind Running

    assign memPowerGood = memAbPowerGood & memCdPowerGood;
    assign allGood      = psPowerOk & mainPowerGood & cpuPowerGood & memPowerGood;
    assign timedOut     = strobes.strobe125ms &&
                          (timer == TimerWidth'(`RAIL_TIMEOUT_STROBES - 1));
    assign sysOkDone    = strobes.strobe125ms &&
                          (timer == TimerWidth'(`SYSOK_DELAY_STROBES - 1));

    //----------------------------------------------------------------------
    // Next state, earlier rails stay supervised while later ones come up
    //----------------------------------------------------------------------
    always_comb begin
        nextState = state;
        unique case (state)
            SeqOff, SeqFault: begin
                if (buttons.powerToggle) nextState = SeqSupplyOn;  // Clears fault
            end
            SeqSupplyOn: begin
                if (timedOut)       nextState = SeqFault;
                else if (psPowerOk) nextState = SeqMainOn;
            end
            SeqMainOn: begin
                if (!psPowerOk || timedOut) nextState = SeqFault;
                else if (mainPowerGood)     nextState = SeqCpuOn;
            end
            SeqCpuOn: begin
                if (!psPowerOk || !mainPowerGood || timedOut) nextState = SeqFault;
                else if (cpuPowerGood)                        nextState = SeqMemOn;
            end
            SeqMemOn: begin
                if (!(psPowerOk & mainPowerGood & cpuPowerGood) || timedOut) begin
                    nextState = SeqFault;
                end else if (memPowerGood) begin
                    nextState = SeqSysOkWait;
                end
            end
            SeqSysOkWait: begin
                if (!allGood)       nextState = SeqFault;
                else if (sysOkDone) nextState = SeqRunning;
            end
            SeqRunning: begin
                if (!allGood)                 nextState = SeqFault;
                else if (buttons.powerToggle) nextState = SeqOff;  // Normal power-off
            end
            default: nextState = SeqOff;
        endcase
    end

    always_ff @(posedge CLK32768) begin
        if (reset) begin
            state      <= SeqOff;
            timer      <= '0;
            pulseCount <= '0;
            resetReady <= 1'b0;
        end else begin
            state      <= nextState;
            resetReady <= (state == SeqRunning);
            if (nextState != state) begin
                timer <= '0;                    // Restart per step
            end else if (strobes.strobe125ms) begin
                timer <= timer + 1'b1;
            end
            // Pulse counts down only once the reset button is released
            if (state != SeqRunning) begin
                pulseCount <= '0;
            end else if (buttons.resetRequest) begin
                pulseCount <= PulseWidth'(`RESET_PULSE_MS);
            end else if (strobes.strobe1ms && !buttons.resetLevel && pulseCount != '0) begin
                pulseCount <= pulseCount - 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // Outputs decode from state, one cycle after the qualifying event
    //----------------------------------------------------------------------
    assign railEnables.supply = (state != SeqOff) && (state != SeqFault);
    assign railEnables.main   = (state >= SeqMainOn) && (state != SeqFault);
    assign railEnables.cpu    = (state >= SeqCpuOn) && (state != SeqFault);
    assign railEnables.mem    = (state >= SeqMemOn) && (state != SeqFault);
    assign sysPowerOk         = (state == SeqRunning);
    assign platformResetN     = resetReady && (state == SeqRunning) && (pulseCount == '0);
    assign faultLedN          = (state != SeqFault);    // Held until next press

endmodule

`default_nettype wire

// ==== hdl/StrobeGen.sv ====
//--------------------------------------------------------------------------
// Strobe generator
// Free-running divider on the 32.768 kHz clock. 16 ms, 125 ms and 1 s
// strobes come from wraps of the divider low bits, 1 ms from its own
// modulo-33 counter
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "boardCtrl_consts.svh"

module StrobeGen (
    input  logic    CLK32768,       // 32.768 kHz standby clock
    input  logic    reset,          // Sync, active high
    StrobeIf.source strobes         // Timing strobes out
);

    localparam int MsWidth     = $clog2(`STROBE_1MS_TICKS);
    localparam int Bits16ms    = $clog2(`STROBE_16MS_TICKS);
    localparam int Bits125ms   = $clog2(`STROBE_125MS_TICKS);

    logic [`DIVIDER_WIDTH-1:0]  divider;    // Counts from reset release
    logic [MsWidth-1:0]         msCount;    // 0 to 32
    logic                       msWrap;

    assign msWrap = (msCount == MsWidth'(`STROBE_1MS_TICKS - 1));

    //----------------------------------------------------------------------
    // Strobes are registered, so each fires exactly N ticks after release
    //----------------------------------------------------------------------
    always_ff @(posedge CLK32768) begin
        if (reset) begin
            divider             <= '0;
            msCount             <= '0;
            strobes.strobe1ms   <= 1'b0;
            strobes.strobe16ms  <= 1'b0;
            strobes.strobe125ms <= 1'b0;
            strobes.strobe1s    <= 1'b0;
        end else begin
            divider             <= divider + 1'b1;
            msCount             <= msWrap ? '0 : msCount + 1'b1;
            strobes.strobe1ms   <= msWrap;
            strobes.strobe16ms  <= &divider[Bits16ms-1:0];     // Low 9 bits wrap
            strobes.strobe125ms <= &divider[Bits125ms-1:0];    // Low 12 bits wrap
            strobes.strobe1s    <= &divider;                   // Full wrap
        end
    end

endmodule

`default_nettype wire

// ==== hdl/StrobeIf.sv ====
//--------------------------------------------------------------------------
// Timing strobe bundle
// Single-cycle 1 ms, 16 ms, 125 ms and 1 s strobes on CLK32768
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface StrobeIf;

    logic strobe1ms;            // Platform reset pulse timing
    logic strobe16ms;           // Button sampling
    logic strobe125ms;          // Rail timeout and power-OK delay
    logic strobe1s;             // Reset button hold

    modport source (
        output strobe1ms, strobe16ms, strobe125ms, strobe1s
    );

    modport sink (
        input strobe1ms, strobe16ms, strobe125ms, strobe1s
    );

endinterface

`default_nettype wire

// ==== hdl/boardCtrl_consts.svh ====
//--------------------------------------------------------------------------
// Board power control constants
// Strobe periods in 32.768 kHz ticks, button debounce and hold counts,
// sequencer delays and the per-rail power-good timeout
//--------------------------------------------------------------------------
`ifndef BOARDCTRL_CONSTS_SVH
`define BOARDCTRL_CONSTS_SVH

//--------------------------------------------------------------------------
// Strobe generator
//--------------------------------------------------------------------------
`define STROBE_1MS_TICKS      33        // About 1.007 ms
`define STROBE_16MS_TICKS     512       // 2^9 ticks
`define STROBE_125MS_TICKS    4096      // 2^12 ticks
`define STROBE_1S_TICKS       32768     // 2^15 ticks, full divider wrap
`define DIVIDER_WIDTH         15        // Free-running divider width

//--------------------------------------------------------------------------
// Buttons
//--------------------------------------------------------------------------
`define DEBOUNCE_SAMPLES      3         // Equal 16 ms samples to accept a level
`define RESET_HOLD_SECONDS    4         // Reset button hold before request

//--------------------------------------------------------------------------
// Sequencer
//--------------------------------------------------------------------------
`define RAIL_TIMEOUT_STROBES  8         // 125 ms strobes, 1 s per rail
`define SYSOK_DELAY_STROBES   2         // Memory good to system power-OK
`define RESET_PULSE_MS        20        // Platform reset pulse in 1 ms strobes

`endif

// ==== verification/BoardCtrlTb.sv ====
//--------------------------------------------------------------------------
// Board power control testbench
// Runs the scenarios of the cases file against the top level, with
// power-good models that answer each rail enable after a random delay
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "boardCtrl_consts.svh"

module BoardCtrlTb import BoardCtrlPkg::*; ();

    localparam int ClkPeriodNs = 40;

    typedef struct {
        int           kind;             // 0 check, 1 power press, 2 drop, 3 reset hold
        int           holdMs;
        int           block;            // Power-good held low, 1-based, 0 none
        int           mode;             // 1 means outputs must stay put
        int           limitMs;
        railEnables_t en;
        logic         sysOk;
        logic         rstN;
        logic         faultN;
    } testCase_t;

    logic           clk, reset;
    logic           powerButtonN, resetButtonN;
    logic [4:0]     pGood;              // PS, main, CPU, mem AB, mem CD
    logic           psEn, mainEn, cpuEn, memEn;
    logic           sysPowerOk, platformResetN, faultLedN, sioPowerButtonN;
    railEnables_t   enables, prevEn;
    testCase_t      cases[$];
    int             blocked = 0;
    int             delay[5];
    integer         seed = 95;
    int             mismatches = 0;
    int             failures = 0;
    logic           loaded = 1'b0;

    assign enables = {psEn, mainEn, cpuEn, memEn};

    ClockGen #(.PeriodNs(ClkPeriodNs), .ResetCycles(4)) uClockGen (.clk(clk), .reset(reset));

    BoardCtrl uut (
        .CLK32768        (clk),
        .reset           (reset),
        .powerButtonN    (powerButtonN),
        .resetButtonN    (resetButtonN),
        .psPowerOk       (pGood[0]),
        .mainPowerGood   (pGood[1]),
        .cpuPowerGood    (pGood[2]),
        .memAbPowerGood  (pGood[3]),
        .memCdPowerGood  (pGood[4]),
        .psEnable        (psEn),
        .mainEnable      (mainEn),
        .cpuEnable       (cpuEn),
        .memEnable       (memEn),
        .sysPowerOk      (sysPowerOk),
        .platformResetN  (platformResetN),
        .faultLedN       (faultLedN),
        .sioPowerButtonN (sioPowerButtonN)
    );

    //----------------------------------------------------------------------
    // Power-good models, each rail answers 1 to 200 cycles after its enable
    //----------------------------------------------------------------------
    initial pGood = '0;

    always @(posedge clk) begin
        logic [4:0] on;
        on = {enables.mem, enables.mem, enables.cpu, enables.main, enables.supply};
        for (int i = 0; i < 5; i++) begin
            if (reset || !on[i] || blocked == i + 1) begin
                pGood[i] <= 1'b0;                               // Off, withheld or dropped
                delay[i] <= 1 + ($unsigned($random(seed)) % 200);
            end else if (delay[i] > 1) begin
                delay[i] <= delay[i] - 1;
            end else begin
                pGood[i] <= 1'b1;
            end
        end
    end

    // Each enable may rise only on its predecessor's power-good
    always @(posedge clk) begin
        if (!reset && ((enables.main && !prevEn.main && !pGood[0]) ||
                       (enables.cpu && !prevEn.cpu && !pGood[1]) ||
                       (enables.mem && !prevEn.mem && !pGood[2]))) begin
            failures++;
            $display("Rail enable rose before its predecessor was good at %0t", $time);
        end
        prevEn <= enables;
    end

    function automatic int msToCycles(input int ms);
        return (ms * `STROBE_1S_TICKS) / 1000;                  // 32.768 ticks per ms
    endfunction

    function automatic logic outputsMatch(input testCase_t c);
        return enables == c.en && sysPowerOk == c.sysOk &&
               platformResetN == c.rstN && faultLedN == c.faultN;
    endfunction

    task automatic checkEnables(input railEnables_t got, input railEnables_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch railEnables at %0t: got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic loadCases();
        int        fd;
        string     line;
        testCase_t c;
        fd = $fopen("verification/boardCtrl_cases.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("Could not open the cases file");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;    // Blank or column notes
            if ($sscanf(line, "%d %d %d %d %d %h %d %d %d", c.kind, c.holdMs, c.block,
                        c.mode, c.limitMs, c.en, c.sysOk, c.rstN, c.faultN) == 9) begin
                cases.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    //----------------------------------------------------------------------
    // One scenario, stimulus first, then wait for or hold the outputs
    //----------------------------------------------------------------------
    task automatic runCase(input int idx, input testCase_t c);
        int   waited;
        logic sawLow;
        logic moved;
        waited = 0;
        sawLow = 1'b0;
        moved  = 1'b0;
        repeat (msToCycles(100)) @(posedge clk);                // Buttons settle
        blocked <= c.block;
        if (c.kind == 1) begin
            powerButtonN <= 1'b0;
            repeat (msToCycles(c.holdMs)) @(posedge clk);
            powerButtonN <= 1'b1;
        end else if (c.kind == 3) begin
            resetButtonN <= 1'b0;
            repeat (msToCycles(c.holdMs)) begin
                @(posedge clk);
                sawLow = sawLow | ~platformResetN;
                moved  = moved | (enables != c.en);
            end
            resetButtonN <= 1'b1;
        end
        if (c.mode == 1) begin
            repeat (msToCycles(c.limitMs)) begin
                @(posedge clk);
                moved = moved | (enables != c.en);
            end
        end else begin
            while (waited < msToCycles(c.limitMs) && !outputsMatch(c)) begin
                @(posedge clk);
                waited++;
            end
        end
        checkEnables(enables, c.en);
        checkLevel("sysPowerOk", sysPowerOk, c.sysOk);
        checkLevel("platformResetN", platformResetN, c.rstN);
        checkLevel("faultLedN", faultLedN, c.faultN);
        if (c.kind == 0) checkLevel("sioPowerButtonN", sioPowerButtonN, 1'b1);
        if (moved) begin
            failures++;
            $display("Case %0d: rail enables changed during the window", idx);
        end
        if (c.kind == 3 && !sawLow) begin
            failures++;
            $display("Case %0d: platform reset never went low while reset was held", idx);
        end
    endtask

    initial begin
        int assertFails;
        powerButtonN = 1'b1;
        resetButtonN = 1'b1;
        loadCases();
        loaded = 1'b1;
        wait (reset === 1'b0);
        @(posedge clk);
        foreach (cases[i]) runCase(i, cases[i]);
        assertFails = uut.uPwrSequence.uProperties.failCount;
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, assertFails);
        if (mismatches == 0 && failures == 0 && assertFails == 0 && cases.size() > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog, six seconds of slow clock per case
    initial begin
        longint limitNs;
        wait (loaded);
        limitNs = longint'(cases.size()) * 6 * `STROBE_1S_TICKS * ClkPeriodNs;
        #(limitNs);
        $display("Run did not finish within %0d ns", limitNs);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/BoardCtrl_properties.sv ====
//--------------------------------------------------------------------------
// Power sequencer properties
// Rail order, power-OK qualification and the all-off fault state
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module BoardCtrlProperties import BoardCtrlPkg::*; (
    input logic         CLK32768,
    input logic         reset,
    input seqState_t    state,
    input railEnables_t railEnables,
    input logic         sysPowerOk,
    input logic [4:0]   goods           // PS, main, CPU, mem AB, mem CD
);

    int failCount = 0;                  // Failed assertion count

    assert property (@(posedge CLK32768) disable iff (reset)
        railEnables.cpu |-> railEnables.main)
        else begin
            failCount++;
            $error("CPU enable asserted without main enable");
        end

    assert property (@(posedge CLK32768) disable iff (reset)
        railEnables.mem |-> railEnables.cpu)
        else begin
            failCount++;
            $error("Memory enable asserted without CPU enable");
        end

    // Sequencer reacts one cycle after a loss, so goods are checked a cycle back
    assert property (@(posedge CLK32768) disable iff (reset)
        sysPowerOk |-> &$past(goods))
        else begin
            failCount++;
            $error("System power-OK high while a power-good was low");
        end

    assert property (@(posedge CLK32768) disable iff (reset)
        (state == SeqFault) |-> (railEnables == 4'h0))
        else begin
            failCount++;
            $error("Rail enabled in the fault state");
        end

endmodule

bind PwrSequence BoardCtrlProperties uProperties (
    .CLK32768    (CLK32768),
    .reset       (reset),
    .state       (state),
    .railEnables (railEnables),
    .sysPowerOk  (sysPowerOk),
    .goods       ({psPowerOk, mainPowerGood, cpuPowerGood, memAbPowerGood, memCdPowerGood})
);

`default_nettype wire

// ==== verification/ClockGen.sv ====
//--------------------------------------------------------------------------
// Testbench clock and reset
// Free-running clock and a synchronous reset held for a few cycles
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ClockGen #(
    parameter int PeriodNs    = 40,     // Simulation clock period
    parameter int ResetCycles = 4       // Cycles of reset after start
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;                  // Release on a rising edge
    end

    always #(PeriodNs / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== verification/boardCtrl_cases.txt ====
# kind(0 check,1 power press,2 drop,3 reset hold) holdMs block(1 ps..5 memCd) mode limitMs
# expected: enables(hex) sysPowerOk platformResetN faultLedN
0 0 0 0 10 0 0 0 1 reset state
1 10 0 1 1000 0 0 0 1 short press ignored
1 100 0 0 500 f 1 1 1 power up
3 5000 0 0 500 f 1 1 1 reset hold pulses platform reset
1 100 0 0 500 0 0 0 1 power off
1 100 3 0 1150 0 0 0 0 cpu good withheld, timeout fault
1 100 0 0 500 f 1 1 1 press clears fault
2 0 4 0 100 0 0 0 0 mem AB good dropped while running
1 100 0 0 500 f 1 1 1 recover
1 100 0 0 500 0 0 0 1 final power off
